//--- rtl/clic_pkg.sv
// Shared definitions for the core-local interrupt subsystem
// Widths, privilege and register address encodings and the cause layout
// Referenced by scoped name from the RTL and the testbench
`default_nettype none

package clic_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned XLEN    = 32;  // Cause word
  localparam int unsigned DATA_W  = 32;  // Wishbone data bus
  localparam int unsigned ADDR_W  = 6;   // Wishbone word address
  localparam int unsigned LEVEL_W = 8;   // Level and threshold

  // Cause layout, bit XLEN-1 marks an interrupt
  localparam int unsigned CAUSE_LEVEL_LSB = 16;
  localparam int unsigned CAUSE_ID_W      = 16;

  // Field positions inside register words
  localparam int unsigned MIL_LSB      = 8;   // mintstatus.mil, sil sits at 0
  localparam int unsigned SRC_PRIV_LSB = 8;   // Source priv field
  localparam int unsigned SRC_EN_BIT   = 16;  // Source enable

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  // Value 2 is reserved and never stored
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Register word addresses
  typedef enum logic [ADDR_W-1:0] {
    REG_PRIV       = 6'h00,  // Hart privilege
    REG_MINTSTATUS = 6'h01,  // mil and sil
    REG_MINTTHRESH = 6'h02,
    REG_SINTTHRESH = 6'h03,
    REG_CTRL       = 6'h04,  // Bit 0 is sie
    REG_SRC_BASE   = 6'h08   // One word per source from here
  } reg_addr_e;

endpackage

`default_nettype wire

//--- rtl/clic_cfg_regs.sv
// Wishbone classic register file of the interrupt subsystem
// Holds the emulated hart status, the thresholds and per-source config
// One-cycle registered ack, byte lanes gate writes
`timescale 1ns/1ps
`default_nettype none

module clic_cfg_regs #(
  parameter int unsigned NumSrc = 8,
  localparam int unsigned IdW = (NumSrc > 1) ? $clog2(NumSrc) : 1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Wishbone slave
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [clic_pkg::ADDR_W-1:0]         wb_adr_i,
  input  logic [clic_pkg::DATA_W-1:0]         wb_dat_i,
  input  logic [clic_pkg::DATA_W/8-1:0]       wb_sel_i,
  output logic [clic_pkg::DATA_W-1:0]         wb_dat_o,
  output logic                                wb_ack_o,
  // Hart status toward the controller
  output clic_pkg::priv_lvl_e                 priv_lvl_o,
  output logic [clic_pkg::LEVEL_W-1:0]        mil_o,
  output logic [clic_pkg::LEVEL_W-1:0]        sil_o,
  output logic [clic_pkg::LEVEL_W-1:0]        mintthresh_o,
  output logic [clic_pkg::LEVEL_W-1:0]        sintthresh_o,
  output logic                                sie_o,
  // Source config toward the arbiter
  output logic [NumSrc-1:0]                   src_en_o,
  output clic_pkg::priv_lvl_e                 src_priv_o  [NumSrc],
  output logic [clic_pkg::LEVEL_W-1:0]        src_level_o [NumSrc]
);

  // Reserved privilege encoding folds to M
  function automatic clic_pkg::priv_lvl_e map_priv(logic [1:0] raw);
    if (raw == 2'b10) return clic_pkg::PRIV_M;
    return clic_pkg::priv_lvl_e'(raw);
  endfunction

  logic                         wb_req;   // New cycle, ack not yet given
  logic                         wb_wr;
  logic [clic_pkg::ADDR_W-1:0]  src_off;
  logic                         src_hit;  // Address inside source window
  logic [IdW-1:0]               src_idx;
  logic [clic_pkg::DATA_W-1:0]  rdata;

  assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wb_wr   = wb_req & wb_we_i;
  assign src_off = wb_adr_i - clic_pkg::ADDR_W'(clic_pkg::REG_SRC_BASE);
  assign src_hit = (wb_adr_i >= clic_pkg::ADDR_W'(clic_pkg::REG_SRC_BASE)) &&
                   (int'(src_off) < NumSrc);
  assign src_idx = src_off[IdW-1:0];

  // ----------------------------------------------------------
  // Bus handshake and read data
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) wb_ack_o <= 1'b0;
    else         wb_ack_o <= wb_req;  // High for exactly one cycle
  end

  always_comb begin
    rdata = '0;  // Unmapped reads zero
    case (wb_adr_i)
      clic_pkg::REG_PRIV:       rdata[1:0] = priv_lvl_o;
      clic_pkg::REG_MINTSTATUS: rdata[15:0] = {mil_o, sil_o};
      clic_pkg::REG_MINTTHRESH: rdata[7:0] = mintthresh_o;
      clic_pkg::REG_SINTTHRESH: rdata[7:0] = sintthresh_o;
      clic_pkg::REG_CTRL:       rdata[0] = sie_o;
      default: begin
        if (src_hit) begin
          rdata[7:0]                      = src_level_o[src_idx];
          rdata[clic_pkg::SRC_PRIV_LSB+:2] = src_priv_o[src_idx];
          rdata[clic_pkg::SRC_EN_BIT]      = src_en_o[src_idx];
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (wb_req) wb_dat_o <= rdata;  // Valid together with the ack
  end

  // ----------------------------------------------------------
  // Register writes, taking effect at the ack edge
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_o   <= clic_pkg::PRIV_M;
      mil_o        <= '0;
      sil_o        <= '0;
      mintthresh_o <= '0;
      sintthresh_o <= '0;
      sie_o        <= 1'b0;
      src_en_o     <= '0;
      for (int unsigned i = 0; i < NumSrc; i++) begin
        src_priv_o[i]  <= clic_pkg::PRIV_U;
        src_level_o[i] <= '0;
      end
    end else if (wb_wr) begin
      case (wb_adr_i)
        clic_pkg::REG_PRIV: begin
          if (wb_sel_i[0]) priv_lvl_o <= map_priv(wb_dat_i[1:0]);
        end
        clic_pkg::REG_MINTSTATUS: begin
          if (wb_sel_i[1]) mil_o <= wb_dat_i[clic_pkg::MIL_LSB+:clic_pkg::LEVEL_W];
          if (wb_sel_i[0]) sil_o <= wb_dat_i[7:0];
        end
        clic_pkg::REG_MINTTHRESH: if (wb_sel_i[0]) mintthresh_o <= wb_dat_i[7:0];
        clic_pkg::REG_SINTTHRESH: if (wb_sel_i[0]) sintthresh_o <= wb_dat_i[7:0];
        clic_pkg::REG_CTRL:       if (wb_sel_i[0]) sie_o <= wb_dat_i[0];
        default: begin
          if (src_hit) begin  // Unmapped words drop the write
            if (wb_sel_i[0]) src_level_o[src_idx] <= wb_dat_i[7:0];
            if (wb_sel_i[1]) begin
              src_priv_o[src_idx] <= map_priv(wb_dat_i[clic_pkg::SRC_PRIV_LSB+:2]);
            end
            if (wb_sel_i[2]) src_en_o[src_idx] <= wb_dat_i[clic_pkg::SRC_EN_BIT];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/clic_arbiter.sv
// Pending bits and source selection of the interrupt subsystem
// Offers the enabled pending source with the highest level, lowest id on ties
// The offer is registered, the core acknowledge clears one pending bit
`timescale 1ns/1ps
`default_nettype none

module clic_arbiter #(
  parameter int unsigned NumSrc = 8,
  localparam int unsigned IdW = (NumSrc > 1) ? $clog2(NumSrc) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [NumSrc-1:0]             irq_src_i,   // Level-sensitive lines
  input  logic [NumSrc-1:0]             src_en_i,
  input  clic_pkg::priv_lvl_e           src_priv_i  [NumSrc],
  input  logic [clic_pkg::LEVEL_W-1:0]  src_level_i [NumSrc],
  input  logic                          ack_i,       // Core took the offer
  input  logic [IdW-1:0]                ack_id_i,
  output logic                          sel_valid_o,
  output logic [IdW-1:0]                sel_id_o,
  output logic [clic_pkg::LEVEL_W-1:0]  sel_level_o,
  output clic_pkg::priv_lvl_e           sel_priv_o
);

  logic [NumSrc-1:0]             pend_q;
  logic [NumSrc-1:0]             clr;   // Acked and line already low
  logic [NumSrc-1:0]             cand;  // Eligible for selection

  logic                          best_vld;
  logic [IdW-1:0]                best_id;
  logic [clic_pkg::LEVEL_W-1:0]  best_lvl;
  clic_pkg::priv_lvl_e           best_priv;

  // ----------------------------------------------------------
  // Pending bits
  // ----------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NumSrc; i++) begin
      clr[i] = ack_i && (ack_id_i == IdW'(i)) && !irq_src_i[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) pend_q <= '0;
    else         pend_q <= (pend_q & ~clr) | irq_src_i;  // High line keeps it set
  end

  // ----------------------------------------------------------
  // Maximum-level search
  // ----------------------------------------------------------
  // Acked source masked so the offer does not repeat for a cycle
  assign cand = pend_q & src_en_i & ~clr;

  always_comb begin
    best_vld  = 1'b0;
    best_id   = '0;
    best_lvl  = '0;
    best_priv = clic_pkg::PRIV_U;
    for (int unsigned i = 0; i < NumSrc; i++) begin
      // Strict compare keeps the lower id on a tie
      if (cand[i] && (!best_vld || (src_level_i[i] > best_lvl))) begin
        best_vld  = 1'b1;
        best_id   = IdW'(i);
        best_lvl  = src_level_i[i];
        best_priv = src_priv_i[i];
      end
    end
  end

  // Registered offer, may move to a higher level under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_valid_o <= 1'b0;
      sel_id_o    <= '0;
      sel_level_o <= '0;
      sel_priv_o  <= clic_pkg::PRIV_U;
    end else begin
      sel_valid_o <= best_vld;
      sel_id_o    <= best_id;
      sel_level_o <= best_lvl;
      sel_priv_o  <= best_priv;
    end
  end

endmodule

`default_nettype wire

//--- rtl/clic_irq_ctrl.sv
// Core-side interrupt controller
// Decides whether the arbiter's offer becomes a trap request to the hart,
// packs the cause word and answers kill requests
`timescale 1ns/1ps
`default_nettype none

module clic_irq_ctrl #(
  parameter int unsigned NumSrc = 8,
  localparam int unsigned IdW = (NumSrc > 1) ? $clog2(NumSrc) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Hart status
  input  clic_pkg::priv_lvl_e           priv_lvl_i,
  input  logic [clic_pkg::LEVEL_W-1:0]  mil_i,
  input  logic [clic_pkg::LEVEL_W-1:0]  sil_i,
  input  logic [clic_pkg::LEVEL_W-1:0]  mintthresh_i,
  input  logic [clic_pkg::LEVEL_W-1:0]  sintthresh_i,
  input  logic                          sie_i,
  // Offer from the arbiter
  input  logic                          irq_valid_i,
  input  logic [IdW-1:0]                irq_id_i,
  input  logic [clic_pkg::LEVEL_W-1:0]  irq_level_i,
  input  clic_pkg::priv_lvl_e           irq_priv_i,
  // Core handshake
  input  logic                          irq_ready_i,  // One-cycle take
  input  logic                          kill_req_i,
  output logic                          kill_ack_o,
  output logic                          irq_req_o,
  output clic_pkg::priv_lvl_e           irq_priv_o,
  output logic [clic_pkg::XLEN-1:0]     irq_cause_o
);

  logic [clic_pkg::LEVEL_W-1:0] m_thresh;  // Effective M threshold
  logic [clic_pkg::LEVEL_W-1:0] s_thresh;  // Effective S threshold
  logic                         irq_inflight_q;

  // ----------------------------------------------------------
  // Acceptance
  // ----------------------------------------------------------
  // Higher of register and current status level
  assign m_thresh = (mintthresh_i > mil_i) ? mintthresh_i : mil_i;
  assign s_thresh = (sintthresh_i > sil_i) ? sintthresh_i : sil_i;

  assign irq_priv_o = irq_priv_i;

  always_comb begin
    irq_req_o = 1'b0;
    case (priv_lvl_i)
      clic_pkg::PRIV_M: begin
        // Only M sources above threshold
        irq_req_o = irq_valid_i && (irq_priv_i == clic_pkg::PRIV_M) &&
                    (irq_level_i > m_thresh);
      end
      clic_pkg::PRIV_S: begin
        if (irq_priv_i == clic_pkg::PRIV_M) begin
          irq_req_o = irq_valid_i;  // M always preempts S
        end else if (irq_priv_i == clic_pkg::PRIV_S) begin
          irq_req_o = irq_valid_i && sie_i && (irq_level_i > s_thresh);
        end
      end
      clic_pkg::PRIV_U: irq_req_o = irq_valid_i;  // Everything valid
      default:          irq_req_o = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Cause packing
  // ----------------------------------------------------------
  always_comb begin
    irq_cause_o = '0;
    irq_cause_o[clic_pkg::XLEN-1] = 1'b1;  // Interrupt flag
    irq_cause_o[clic_pkg::CAUSE_LEVEL_LSB+:clic_pkg::LEVEL_W] = irq_level_i;
    irq_cause_o[clic_pkg::CAUSE_ID_W-1:0] = clic_pkg::CAUSE_ID_W'(irq_id_i);
  end

  // ----------------------------------------------------------
  // Kill control
  // ----------------------------------------------------------
  // Ack only when nothing is in flight and nothing requested now
  assign kill_ack_o = kill_req_i & ~irq_inflight_q & ~irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_inflight_q <= 1'b0;
    end else if (irq_ready_i || kill_ack_o) begin
      irq_inflight_q <= 1'b0;  // Taken or killed
    end else if (irq_req_o) begin
      irq_inflight_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/clic_top.sv
// Top level of the core-local interrupt subsystem
// Wishbone config port, source lines in, trap request handshake to the core
`timescale 1ns/1ps
`default_nettype none

module clic_top #(
  parameter int unsigned NumSrc = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Wishbone slave
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [clic_pkg::ADDR_W-1:0]    wb_adr_i,
  input  logic [clic_pkg::DATA_W-1:0]    wb_dat_i,
  input  logic [clic_pkg::DATA_W/8-1:0]  wb_sel_i,
  output logic [clic_pkg::DATA_W-1:0]    wb_dat_o,
  output logic                           wb_ack_o,
  // Sources and core
  input  logic [NumSrc-1:0]              irq_src_i,
  input  logic                           irq_ready_i,
  input  logic                           kill_req_i,
  output logic                           irq_req_o,
  output clic_pkg::priv_lvl_e            irq_priv_o,
  output logic [clic_pkg::XLEN-1:0]      irq_cause_o,
  output logic                           kill_ack_o
);

  localparam int unsigned IdW = (NumSrc > 1) ? $clog2(NumSrc) : 1;

  // Hart status
  clic_pkg::priv_lvl_e           priv_lvl;
  logic [clic_pkg::LEVEL_W-1:0]  mil, sil, mintthresh, sintthresh;
  logic                          sie;
  // Source config
  logic [NumSrc-1:0]             src_en;
  clic_pkg::priv_lvl_e           src_priv  [NumSrc];
  logic [clic_pkg::LEVEL_W-1:0]  src_level [NumSrc];
  // Offer
  logic                          sel_valid;
  logic [IdW-1:0]                sel_id;
  logic [clic_pkg::LEVEL_W-1:0]  sel_level;
  clic_pkg::priv_lvl_e           sel_priv;

  clic_cfg_regs #(.NumSrc(NumSrc)) i_cfg_regs (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .priv_lvl_o   (priv_lvl),
    .mil_o        (mil),
    .sil_o        (sil),
    .mintthresh_o (mintthresh),
    .sintthresh_o (sintthresh),
    .sie_o        (sie),
    .src_en_o     (src_en),
    .src_priv_o   (src_priv),
    .src_level_o  (src_level)
  );

  clic_arbiter #(.NumSrc(NumSrc)) i_arbiter (
    .clk_i, .rst_ni, .irq_src_i,
    .src_en_i    (src_en),
    .src_priv_i  (src_priv),
    .src_level_i (src_level),
    .ack_i       (irq_ready_i),  // Core take clears the offered source
    .ack_id_i    (sel_id),
    .sel_valid_o (sel_valid),
    .sel_id_o    (sel_id),
    .sel_level_o (sel_level),
    .sel_priv_o  (sel_priv)
  );

  clic_irq_ctrl #(.NumSrc(NumSrc)) i_irq_ctrl (
    .clk_i, .rst_ni,
    .priv_lvl_i   (priv_lvl),
    .mil_i        (mil),
    .sil_i        (sil),
    .mintthresh_i (mintthresh),
    .sintthresh_i (sintthresh),
    .sie_i        (sie),
    .irq_valid_i  (sel_valid),
    .irq_id_i     (sel_id),
    .irq_level_i  (sel_level),
    .irq_priv_i   (sel_priv),
    .irq_ready_i, .kill_req_i, .kill_ack_o,
    .irq_req_o, .irq_priv_o, .irq_cause_o
  );

endmodule

`default_nettype wire

//--- testbench/clic_props.sv
// Concurrent checks on the kill and Wishbone handshakes
// Bound into the top level, reaches the controller's in-flight flag by path
`timescale 1ns/1ps
`default_nettype none

module clic_props (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_ack_i,
  input logic irq_req_i,
  input logic irq_ready_i,
  input logic kill_ack_i,
  input logic inflight_i
);

  // Request not taken puts it in flight and holds off the kill ack
  kill_vs_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_req_i && !irq_ready_i) |=> (inflight_i && !kill_ack_i))
    else $error("No in-flight flag or kill_ack_o high after an untaken request");

  // Classic ack is a single-cycle pulse
  wb_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o high two cycles in a row");

  req_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !irq_req_i)
    else $error("irq_req_o high during reset");

endmodule

bind clic_top clic_props i_props (
  .clk_i,
  .rst_ni,
  .wb_ack_i    (wb_ack_o),
  .irq_req_i   (irq_req_o),
  .irq_ready_i,
  .kill_ack_i  (kill_ack_o),
  .inflight_i  (i_irq_ctrl.irq_inflight_q)  // Controller state
);

`default_nettype wire

//--- testbench/tb_clic_top.sv
// Self-checking testbench for the interrupt subsystem top level
// Acts as Wishbone master and as the core, checks against a register and pending model
`timescale 1ns/1ps
`default_nettype none

module tb_clic_top;

  localparam int NUM_SRC   = 8;
  localparam int SRC_BASE  = int'(clic_pkg::REG_SRC_BASE);
  localparam int N_WR      = 40;  // Random register writes
  localparam int N_SEL     = 30;  // Selection rounds
  localparam int N_THR     = 40;  // Threshold rounds
  localparam int N_KILL    = 8;
  localparam int NUM_TESTS = N_WR + 64 + N_SEL + N_THR + N_KILL;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 200;

  logic                              clk_i, rst_ni;
  logic                              wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [clic_pkg::ADDR_W-1:0]       wb_adr_i;
  logic [clic_pkg::DATA_W-1:0]       wb_dat_i, wb_dat_o;
  logic [clic_pkg::DATA_W/8-1:0]     wb_sel_i;
  logic [NUM_SRC-1:0]                irq_src_i;
  logic                              irq_ready_i, kill_req_i, irq_req_o, kill_ack_o;
  clic_pkg::priv_lvl_e               irq_priv_o;
  logic [clic_pkg::XLEN-1:0]         irq_cause_o;
  integer                            seed = 56;

  // ----------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------
  clic_pkg::priv_lvl_e               m_priv;
  logic [clic_pkg::LEVEL_W-1:0]      m_mil, m_sil, m_mth, m_sth;
  logic                              m_sie;
  logic                              m_en    [NUM_SRC];
  clic_pkg::priv_lvl_e               m_spriv [NUM_SRC];
  logic [clic_pkg::LEVEL_W-1:0]      m_level [NUM_SRC];
  logic                              m_pend  [NUM_SRC];

  clic_top #(.NumSrc(NUM_SRC)) i_clic_top (.*);

  always #50 clk_i = ~clk_i;  // 100 ns period

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_req(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %0b actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_priv(input string name, input clic_pkg::priv_lvl_e exp,
                            input clic_pkg::priv_lvl_e act);
    if (act !== exp) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cause(input string name, input logic [clic_pkg::XLEN-1:0] exp,
                             input logic [clic_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Reserved encoding 2 reads back as M
  function automatic clic_pkg::priv_lvl_e fold_priv(logic [1:0] raw);
    return (raw == 2'b10) ? clic_pkg::PRIV_M : clic_pkg::priv_lvl_e'(raw);
  endfunction

  task automatic model_reset();
    m_priv = clic_pkg::PRIV_M;
    {m_mil, m_sil, m_mth, m_sth, m_sie} = '0;
    for (int i = 0; i < NUM_SRC; i++) begin
      m_en[i]    = 1'b0;
      m_spriv[i] = clic_pkg::PRIV_U;
      m_level[i] = '0;
      m_pend[i]  = 1'b0;
    end
  endtask

  function automatic void model_write(logic [5:0] adr, logic [31:0] d, logic [3:0] sel);
    int i;
    i = int'(adr) - SRC_BASE;
    if (adr == clic_pkg::REG_PRIV && sel[0]) m_priv = fold_priv(d[1:0]);
    if (adr == clic_pkg::REG_MINTSTATUS && sel[1]) m_mil = d[15:8];
    if (adr == clic_pkg::REG_MINTSTATUS && sel[0]) m_sil = d[7:0];
    if (adr == clic_pkg::REG_MINTTHRESH && sel[0]) m_mth = d[7:0];
    if (adr == clic_pkg::REG_SINTTHRESH && sel[0]) m_sth = d[7:0];
    if (adr == clic_pkg::REG_CTRL && sel[0]) m_sie = d[0];
    if (i >= 0 && i < NUM_SRC) begin  // Per-source word
      if (sel[0]) m_level[i] = d[7:0];
      if (sel[1]) m_spriv[i] = fold_priv(d[9:8]);
      if (sel[2]) m_en[i] = d[16];
    end
  endfunction

  function automatic logic [31:0] model_read(logic [5:0] adr);
    logic [31:0] d;
    int          i;
    d = '0;  // Unmapped reads zero
    i = int'(adr) - SRC_BASE;
    if (adr == clic_pkg::REG_PRIV) d[1:0] = m_priv;
    if (adr == clic_pkg::REG_MINTSTATUS) d[15:0] = {m_mil, m_sil};
    if (adr == clic_pkg::REG_MINTTHRESH) d[7:0] = m_mth;
    if (adr == clic_pkg::REG_SINTTHRESH) d[7:0] = m_sth;
    if (adr == clic_pkg::REG_CTRL) d[0] = m_sie;
    if (i >= 0 && i < NUM_SRC) d = {15'b0, m_en[i], 6'b0, m_spriv[i], m_level[i]};
    return d;
  endfunction

  // Highest level among enabled pending, first id wins a tie
  task automatic model_winner(output logic vld, output int w);
    vld = 1'b0;
    w   = 0;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (m_pend[i] && m_en[i] && (!vld || m_level[i] > m_level[w])) begin
        vld = 1'b1;
        w   = i;
      end
    end
  endtask

  function automatic logic accept(int w);
    logic [7:0] mt, st;
    mt = (m_mth > m_mil) ? m_mth : m_mil;
    st = (m_sth > m_sil) ? m_sth : m_sil;
    case (m_priv)
      clic_pkg::PRIV_M: return m_spriv[w] == clic_pkg::PRIV_M && m_level[w] > mt;
      clic_pkg::PRIV_S: return m_spriv[w] == clic_pkg::PRIV_M ||
                               (m_spriv[w] == clic_pkg::PRIV_S && m_sie && m_level[w] > st);
      default:          return 1'b1;  // U takes all
    endcase
  endfunction

  function automatic logic [clic_pkg::XLEN-1:0] exp_cause(int w);
    logic [clic_pkg::XLEN-1:0] c;
    c = '0;
    c[clic_pkg::XLEN-1] = 1'b1;
    c[clic_pkg::CAUSE_LEVEL_LSB+:clic_pkg::LEVEL_W] = m_level[w];
    c[clic_pkg::CAUSE_ID_W-1:0] = clic_pkg::CAUSE_ID_W'(w);
    return c;
  endfunction

  // ----------------------------------------------------------
  // Bus and core drivers, all start and end at a falling edge
  // ----------------------------------------------------------
  task automatic wb_cycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    int n;
    {wb_cyc_i, wb_stb_i, wb_we_i} = {2'b11, we};
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_ack_o && n < 8);
    if (!wb_ack_o) begin
      $display("Wishbone access to address %0h got no ack", adr);
      abort_run();
    end
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
  endtask

  task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    wb_cycle(1'b1, adr, dat, sel);
    model_write(adr, dat, sel);
  endtask

  task automatic wb_read(input logic [5:0] adr, output logic [31:0] dat);
    wb_cycle(1'b0, adr, '0, 4'hF);
    dat = wb_dat_o;  // Held until the next access
  endtask

  task automatic write_source(input int i, input logic en, input logic [1:0] praw,
                              input logic [7:0] lvl);
    wb_write(6'(SRC_BASE + i), {15'b0, en, 6'b0, praw, lvl}, 4'hF);
  endtask

  // One-cycle pulse, offer visible two edges later
  task automatic pulse_sources(input logic [NUM_SRC-1:0] pat);
    irq_src_i = pat;
    @(negedge clk_i);
    irq_src_i = '0;
    for (int i = 0; i < NUM_SRC; i++) if (pat[i]) m_pend[i] = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic take_irq(input int w, input logic hold);
    irq_ready_i = 1'b1;
    if (hold) irq_src_i[w] = 1'b1;  // Line still high keeps it pending
    @(negedge clk_i);
    irq_ready_i = 1'b0;
    irq_src_i   = '0;
    if (!hold) m_pend[w] = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic check_offer(input string name, input logic exp_req, input logic vld,
                             input int w);
    check_req(name, exp_req, irq_req_o);
    if (vld) begin
      check_cause(name, exp_cause(w), irq_cause_o);
      check_priv(name, m_spriv[w], irq_priv_o);
    end
  endtask

  // Take offers one by one in U mode
  task automatic drain_pending(input logic allow_hold);
    logic vld;
    int   w;
    int   n;
    n = 0;
    model_winner(vld, w);
    while (vld && n < 12) begin
      check_offer("ack next", 1'b1, 1'b1, w);
      take_irq(w, allow_hold && (rand32() % 4 == 0));
      model_winner(vld, w);
      n++;
    end
    if (!vld) check_req("drained", 1'b0, irq_req_o);
  endtask

  // Watchdog sized from the test counts
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  initial begin
    logic [31:0] r, rd;
    logic        vld, exp;
    int          w;
    clk_i = 1'b0;
    rst_ni = 1'b1;
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    irq_src_i = '0;
    irq_ready_i = 1'b0;
    kill_req_i = 1'b0;
    model_reset();
    #1 rst_ni = 1'b0;  // Clean falling edge for the async reset
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // Register readback
    for (int n = 0; n < N_WR; n++) begin
      r = rand32();
      wb_write({1'b0, r[4:0]}, rand32(), r[11:8]);
    end
    wb_write(clic_pkg::REG_PRIV, 32'h2, 4'h1);  // Reserved value
    wb_write(6'(SRC_BASE + 3), 32'h0001_0200, 4'h6);
    for (int a = 0; a < 64; a++) begin
      wb_read(6'(a), rd);
      check_data("readback", model_read(6'(a)), rd);
    end

    // Source selection and acknowledge, U mode takes all
    wb_write(clic_pkg::REG_PRIV, 32'(clic_pkg::PRIV_U), 4'hF);
    for (int n = 0; n < N_SEL; n++) begin
      for (int i = 0; i < NUM_SRC; i++) begin
        r = rand32();
        write_source(i, r[3:0] != 4'h0, r[9:8], {5'b0, r[18:16]});  // Narrow levels tie often
      end
      r = rand32();
      pulse_sources(r[NUM_SRC-1:0]);
      model_winner(vld, w);
      check_offer("select", vld, vld, w);
      drain_pending(1'b1);
    end

    // Threshold acceptance in M and S mode
    for (int n = 0; n < N_THR; n++) begin
      r = rand32();
      wb_write(clic_pkg::REG_PRIV, r[0] ? 32'(clic_pkg::PRIV_M) : 32'(clic_pkg::PRIV_S), 4'h1);
      wb_write(clic_pkg::REG_MINTSTATUS, {21'b0, r[4:2], 5'b0, r[7:5]}, 4'h3);
      wb_write(clic_pkg::REG_MINTTHRESH, {29'b0, r[10:8]}, 4'h1);
      wb_write(clic_pkg::REG_SINTTHRESH, {29'b0, r[13:11]}, 4'h1);
      wb_write(clic_pkg::REG_CTRL, {31'b0, r[14]}, 4'h1);
      pulse_sources(r[23:16] | 8'h01);
      model_winner(vld, w);
      exp = vld && accept(w);
      check_offer("threshold", exp, vld, w);
      if (exp) take_irq(w, 1'b0);
    end

    // Kill handshake from a drained, idle state
    wb_write(clic_pkg::REG_PRIV, 32'(clic_pkg::PRIV_U), 4'hF);
    for (int i = 0; i < NUM_SRC; i++) write_source(i, 1'b1, 2'b11, 8'(i));
    pulse_sources(8'h01);
    drain_pending(1'b0);
    for (int n = 0; n < N_KILL; n++) begin
      kill_req_i = 1'b1;
      #1 check_req("kill idle", 1'b1, kill_ack_o);  // Same-cycle ack
      @(negedge clk_i);
      kill_req_i = 1'b0;
      r = rand32();
      pulse_sources(8'(1 << r[2:0]));
      check_req("kill request", 1'b1, irq_req_o);
      if (r[6]) begin
        // Take in the first request cycle before the flag is set
        take_irq(int'(r[2:0]), 1'b0);
        kill_req_i = 1'b1;
        #1 check_req("kill after early take", 1'b1, kill_ack_o);
        @(negedge clk_i);
        kill_req_i = 1'b0;
      end else begin
        @(negedge clk_i);  // Flag set by now
        kill_req_i = 1'b1;
        repeat (1 + r[5:4]) begin
          #1 check_req("kill in flight", 1'b0, kill_ack_o);
          @(negedge clk_i);
        end
        irq_ready_i = 1'b1;
        #1 check_req("kill at take", 1'b0, kill_ack_o);
        @(negedge clk_i);
        irq_ready_i = 1'b0;
        m_pend[r[2:0]] = 1'b0;
        #1 check_req("kill after take", 1'b1, kill_ack_o);
        @(negedge clk_i);
        kill_req_i = 1'b0;
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/clic_pkg.sv
rtl/clic_cfg_regs.sv
rtl/clic_arbiter.sv
rtl/clic_irq_ctrl.sv
rtl/clic_top.sv
testbench/clic_props.sv
testbench/tb_clic_top.sv
